// ==== design/flit_buffer_pkg.sv ====
package flit_buffer_pkg;

    // buffer geometry
    localparam int num_vc    = 4;   // virtual channels per input port
    localparam int vc_depth  = 4;   // flit slots per vc, power of two
    localparam int payload_w = 32;
    localparam int hdr_w     = 2;   // header and tail flags

    // incoming flit is header, one-hot vc field, payload
    localparam int flit_w = hdr_w + num_vc + payload_w;

    // the vc field is implied by the write select, so the ram drops it
    localparam int ram_data_w = hdr_w + payload_w;

    // pointer inside one vc region
    localparam int ptr_w = (vc_depth > 1) ? $clog2(vc_depth) : 1;

    // binary vc number
    localparam int vc_w = (num_vc > 1) ? $clog2(num_vc) : 1;

    // ram address is vc number followed by the in-vc pointer
    localparam int addr_w = vc_w + ptr_w;

    // occupancy has to reach vc_depth itself
    localparam int depth_w = ptr_w + 1;

endpackage

// ==== design/vc_ram_if.sv ====
`timescale 1ns/1ps

// address and strobe bus from the pointer controller to the flit ram
interface vc_ram_if import flit_buffer_pkg::*; ();

    logic              wr;       // single cycle write strobe
    logic              rd;       // single cycle read strobe
    logic [addr_w-1:0] wr_addr;
    logic [addr_w-1:0] rd_addr;

    // controller side
    modport ctrl (
        output wr,
        output rd,
        output wr_addr,
        output rd_addr
    );

    // ram side
    modport ram (
        input wr,
        input rd,
        input wr_addr,
        input rd_addr
    );

endinterface

// ==== design/vc_ptr_ctrl.sv ====
`timescale 1ns/1ps

module vc_ptr_ctrl import flit_buffer_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic [num_vc-1:0] vc_num_wr,    // one-hot
    input  logic              rd_en,
    input  logic [num_vc-1:0] vc_num_rd,    // one-hot
    output logic [num_vc-1:0] vc_not_empty,
    vc_ram_if.ctrl            ram
);

    logic [num_vc-1:0]  wr_vc;    // write strobe per vc
    logic [num_vc-1:0]  rd_vc;    // read strobe per vc
    logic [num_vc-1:0]  vc_full;
    logic [ptr_w-1:0]   wr_ptr [num_vc];
    logic [ptr_w-1:0]   rd_ptr [num_vc];
    logic [depth_w-1:0] depth  [num_vc];
    logic [vc_w-1:0]    wr_vc_bin;
    logic [vc_w-1:0]    rd_vc_bin;

    // OR of the indices of the set bits, exact for a one-hot input
    function automatic logic [vc_w-1:0] onehot_to_bin(input logic [num_vc-1:0] onehot);
        logic [vc_w-1:0] bin;
        bin = '0;
        for (int i = 0; i < num_vc; i++) begin
            if (onehot[i]) begin
                bin = bin | vc_w'(i);
            end
        end
        return bin;
    endfunction

    assign wr_vc = wr_en ? vc_num_wr : '0;
    assign rd_vc = rd_en ? vc_num_rd : '0;

    assign wr_vc_bin = onehot_to_bin(vc_num_wr);
    assign rd_vc_bin = onehot_to_bin(vc_num_rd);

    // each vc owns a contiguous region, so the vc number is the upper address part
    assign ram.wr_addr = {wr_vc_bin, wr_ptr[wr_vc_bin]};
    assign ram.rd_addr = {rd_vc_bin, rd_ptr[rd_vc_bin]};
    assign ram.wr      = wr_en;
    assign ram.rd      = rd_en;

    genvar i;
    generate
        for (i = 0; i < num_vc; i++) begin : g_vc
            assign vc_not_empty[i] = (depth[i] != '0);
            assign vc_full[i]      = (depth[i] == depth_w'(vc_depth));

            always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                    wr_ptr[i] <= '0;
                    rd_ptr[i] <= '0;
                    depth[i]  <= '0;
                end else begin
                    // pointers wrap on their own, vc_depth is a power of two
                    if (wr_vc[i]) begin
                        wr_ptr[i] <= wr_ptr[i] + ptr_w'(1);
                    end
                    if (rd_vc[i]) begin
                        rd_ptr[i] <= rd_ptr[i] + ptr_w'(1);
                    end

                    if (wr_vc[i] && !rd_vc[i]) begin
                        depth[i] <= depth[i] + depth_w'(1);
                    end else if (rd_vc[i] && !wr_vc[i]) begin
                        depth[i] <= depth[i] - depth_w'(1);
                    end
                    // write and read together leave the depth alone
                end
            end
        end
    endgenerate

    // writer keeps out of full vcs, except when the same vc drains this cycle
    a_wr_legal: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> $onehot(vc_num_wr) && ((wr_vc & vc_full & ~rd_vc) == '0)
    ) else $error("write with bad vc select or to a full vc");

    // plain read of an empty vc
    a_rd_legal: assert property (
        @(posedge clk) disable iff (reset)
        rd_en |-> $onehot(vc_num_rd) && ((rd_vc & ~wr_vc & ~vc_not_empty) == '0)
    ) else $error("read with bad vc select or from an empty vc");

    // no write-through, the ram returns the old word
    a_no_bypass: assert property (
        @(posedge clk) disable iff (reset)
        (wr_vc & rd_vc & ~vc_not_empty) == '0
    ) else $error("write and read of the same empty vc in one cycle");

endmodule

// ==== design/flit_ram.sv ====
`timescale 1ns/1ps

module flit_ram import flit_buffer_pkg::*; (
    input  logic                  clk,
    input  logic [ram_data_w-1:0] din,
    output logic [ram_data_w-1:0] dout,
    vc_ram_if.ram                 ram
);

    // one region of vc_depth words per vc
    logic [ram_data_w-1:0] mem [num_vc*vc_depth];

    always_ff @(posedge clk) begin
        if (ram.wr) begin
            mem[ram.wr_addr] <= din;
        end
        // registered read, holds between reads
        if (ram.rd) begin
            dout <= mem[ram.rd_addr];   // old word on a same address write
        end
    end

    // addresses come from the pointer controller and must be settled on a strobe
    a_wr_addr_known: assert property (
        @(posedge clk) ram.wr |-> !$isunknown(ram.wr_addr)
    ) else $error("unknown write address with write strobe high");

    a_rd_addr_known: assert property (
        @(posedge clk) ram.rd |-> !$isunknown(ram.rd_addr)
    ) else $error("unknown read address with read strobe high");

endmodule

// ==== design/flit_buffer.sv ====
`timescale 1ns/1ps

// input port flit buffer, all vcs share one ram
module flit_buffer import flit_buffer_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [flit_w-1:0]     din,
    input  logic                  wr_en,
    input  logic [num_vc-1:0]     vc_num_wr,
    input  logic                  rd_en,
    input  logic [num_vc-1:0]     vc_num_rd,
    output logic [ram_data_w-1:0] dout,          // header then payload
    output logic [num_vc-1:0]     vc_not_empty
);

    logic [hdr_w-1:0]      din_hdr;
    logic [payload_w-1:0]  din_payload;
    logic [ram_data_w-1:0] ram_din;

    // din is header, vc field, payload from msb down
    assign din_hdr     = din[flit_w-1 -: hdr_w];
    assign din_payload = din[payload_w-1:0];

    // vc field is dropped here
    assign ram_din = {din_hdr, din_payload};

    vc_ram_if ram_bus ();

    vc_ptr_ctrl u_ptr_ctrl (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .vc_num_wr    (vc_num_wr),
        .rd_en        (rd_en),
        .vc_num_rd    (vc_num_rd),
        .vc_not_empty (vc_not_empty),
        .ram          (ram_bus)
    );

    // ram output word already has the dout layout
    flit_ram u_ram (
        .clk  (clk),
        .din  (ram_din),
        .dout (dout),
        .ram  (ram_bus)
    );

endmodule

// ==== dv/flit_buffer_scoreboard.sv ====
`timescale 1ns/1ps

// reference model of the vc buffer, one queue per vc
module flit_buffer_scoreboard import flit_buffer_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [flit_w-1:0]     din,
    input  logic                  wr_en,
    input  logic [num_vc-1:0]     vc_num_wr,
    input  logic                  rd_en,
    input  logic [num_vc-1:0]     vc_num_rd,
    input  logic [ram_data_w-1:0] dout,
    input  logic [num_vc-1:0]     vc_not_empty,
    output int                    fail_count,
    output int                    read_count
);

    logic [ram_data_w-1:0] ref_q [num_vc][$];
    logic [ram_data_w-1:0] exp_dout;        // word the last read should show
    logic                  have_dout;       // at least one read since reset
    logic [num_vc-1:0]     exp_not_empty;

    // index of the selected vc in a one-hot select
    function automatic int vc_index(input logic [num_vc-1:0] sel);
        int idx;
        idx = 0;
        for (int i = 0; i < num_vc; i++) begin
            if (sel[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    initial fail_count = 0;

    always @(posedge clk or posedge reset) begin : update_model
        int                    wv;
        int                    rv;
        logic [ram_data_w-1:0] word;
        if (reset) begin
            for (int i = 0; i < num_vc; i++) begin
                ref_q[i].delete();
            end
            have_dout     <= 1'b0;
            exp_not_empty <= '0;
            read_count    = 0;
        end else begin
            wv = vc_index(vc_num_wr);
            rv = vc_index(vc_num_rd);
            // pop before push, a same-vc pair only happens on a non-empty vc
            if (rd_en && ref_q[rv].size() > 0) begin
                word = ref_q[rv].pop_front();
                exp_dout   <= word;
                have_dout  <= 1'b1;
                read_count = read_count + 1;
            end
            if (wr_en) begin
                // stored word is header and payload, vc field left out
                ref_q[wv].push_back({din[flit_w-1:flit_w-hdr_w], din[payload_w-1:0]});
            end
            for (int i = 0; i < num_vc; i++) begin
                exp_not_empty[i] <= (ref_q[i].size() != 0);
            end
        end
    end

    a_reset_empty: assert property (
        @(posedge clk) $fell(reset) |-> vc_not_empty == '0
    ) else begin
        fail_count++;
        $display("CHECK FAILED at %0t: vc_not_empty %b right after reset",
                 $time, $sampled(vc_not_empty));
    end

    // flags follow the queues with one cycle of latency
    a_not_empty: assert property (
        @(posedge clk) disable iff (reset) vc_not_empty == exp_not_empty
    ) else begin
        fail_count++;
        $display("CHECK FAILED at %0t: vc_not_empty %b, expected %b",
                 $time, $sampled(vc_not_empty), $sampled(exp_not_empty));
    end

    a_dout_value: assert property (
        @(posedge clk) disable iff (reset) have_dout |-> dout == exp_dout
    ) else begin
        fail_count++;
        $display("CHECK FAILED at %0t: dout %h, expected %h",
                 $time, $sampled(dout), $sampled(exp_dout));
    end

    a_dout_hold: assert property (
        @(posedge clk) disable iff (reset) have_dout && !$past(rd_en) |-> $stable(dout)
    ) else begin
        fail_count++;
        $display("CHECK FAILED at %0t: dout changed without a read", $time);
    end

endmodule

// ==== dv/flit_buffer_tb.sv ====
`timescale 1ns/1ps

module flit_buffer_tb import flit_buffer_pkg::*; ();

    localparam logic [15:0] lfsr_seed   = 16'd26;
    localparam int          wait_limit  = 50;    // cycles per wait
    localparam int          rand_cycles = 200;

    logic                  clk;
    logic                  reset;
    logic [flit_w-1:0]     din;
    logic                  wr_en;
    logic [num_vc-1:0]     vc_num_wr;
    logic                  rd_en;
    logic [num_vc-1:0]     vc_num_rd;
    logic [ram_data_w-1:0] dout;
    logic [num_vc-1:0]     vc_not_empty;

    logic [15:0] lfsr;
    int          cnt [num_vc];     // flits held per vc as the stimulus sees it
    int          fail_count;
    int          read_count;
    int          tests_run;
    int          tests_failed;
    event        abort_run;

    flit_buffer u_flit_buffer (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .wr_en        (wr_en),
        .vc_num_wr    (vc_num_wr),
        .rd_en        (rd_en),
        .vc_num_rd    (vc_num_rd),
        .dout         (dout),
        .vc_not_empty (vc_not_empty)
    );

    flit_buffer_scoreboard u_scoreboard (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .wr_en        (wr_en),
        .vc_num_wr    (vc_num_wr),
        .rd_en        (rd_en),
        .vc_num_rd    (vc_num_rd),
        .dout         (dout),
        .vc_not_empty (vc_not_empty),
        .fail_count   (fail_count),
        .read_count   (read_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr stepped once per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[i] = lfsr[0];
            lfsr   = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [num_vc-1:0] onehot(input int vc);
        logic [num_vc-1:0] sel;
        sel     = '0;
        sel[vc] = 1'b1;
        return sel;
    endfunction

    task automatic build_flit(input int vc, output logic [flit_w-1:0] flit);
        logic [31:0] h;
        logic [31:0] p;
        h    = take_bits(hdr_w);
        p    = take_bits(payload_w);
        flit = {h[hdr_w-1:0], onehot(vc), p[payload_w-1:0]};
    endtask

    // one cycle of stimulus applied on the falling edge
    task automatic drive(input logic w, input int wvc, input logic r, input int rvc);
        logic [flit_w-1:0] flit;
        flit = '0;
        if (w) begin
            build_flit(wvc, flit);
        end
        @(negedge clk);
        din       = flit;
        wr_en     = w;
        vc_num_wr = w ? onehot(wvc) : '0;
        rd_en     = r;
        vc_num_rd = r ? onehot(rvc) : '0;
        if (w) cnt[wvc]++;
        if (r) cnt[rvc]--;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            drive(1'b0, 0, 1'b0, 0);
        end
    endtask

    // idles until the masked flags reach the level
    task automatic wait_flags(input logic [num_vc-1:0] mask, input logic [num_vc-1:0] level);
        int n;
        n = 0;
        while (((vc_not_empty ^ level) & mask) != '0 && n < wait_limit) begin
            drive(1'b0, 0, 1'b0, 0);
            n++;
        end
        if (((vc_not_empty ^ level) & mask) != '0) begin
            $display("timeout: vc_not_empty stuck at %b, waited for %b under mask %b",
                     vc_not_empty, level, mask);
            -> abort_run;
        end
    endtask

    task automatic drain_all();
        for (int v = 0; v < num_vc; v++) begin
            while (cnt[v] > 0) begin
                drive(1'b0, 0, 1'b1, v);
            end
        end
        wait_flags('1, '0);
    endtask

    task automatic finish_test(input string name, input int start_fails);
        tests_run++;
        if (fail_count > start_fails) begin
            tests_failed++;
            $display("test %0d %s: %0d check failures", tests_run, name, fail_count - start_fails);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
    endtask

    initial begin
        @(abort_run);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [31:0] bits;
        logic        w;
        logic        r;
        int          wvc;
        int          rvc;
        int          start;
        reset        = 1'b1;
        din          = '0;
        wr_en        = 1'b0;
        vc_num_wr    = '0;
        rd_en        = 1'b0;
        vc_num_rd    = '0;
        lfsr         = lfsr_seed;
        tests_run    = 0;
        tests_failed = 0;
        for (int v = 0; v < num_vc; v++) begin
            cnt[v] = 0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start = fail_count;
        idle_cycles(3);
        wait_flags('1, '0);
        finish_test("reset state", start);

        start = fail_count;
        for (int i = 0; i < vc_depth; i++) drive(1'b1, 1, 1'b0, 0);
        for (int i = 0; i < vc_depth; i++) drive(1'b0, 0, 1'b1, 1);
        drain_all();
        finish_test("single vc order", start);

        start = fail_count;
        for (int k = 0; k < rand_cycles; k++) begin
            bits = take_bits(1);
            w    = bits[0];
            bits = take_bits(vc_w);
            wvc  = int'(bits[vc_w-1:0]);
            bits = take_bits(1);
            r    = bits[0];
            bits = take_bits(vc_w);
            rvc  = int'(bits[vc_w-1:0]);
            if (cnt[wvc] >= vc_depth) w = 1'b0;   // never overfill
            if (cnt[rvc] == 0) r = 1'b0;          // never read empty
            drive(w, wvc, r, rvc);
        end
        drain_all();
        finish_test("random interleave", start);

        start = fail_count;
        drive(1'b1, 2, 1'b0, 0);
        wait_flags(4'b0100, 4'b0100);
        while (cnt[2] < vc_depth) drive(1'b1, 2, 1'b0, 0);
        while (cnt[2] > 0) drive(1'b0, 0, 1'b1, 2);
        wait_flags(4'b0100, 4'b0000);
        finish_test("fill and drain", start);

        start = fail_count;
        drive(1'b1, 3, 1'b0, 0);
        drive(1'b1, 3, 1'b0, 0);
        drive(1'b1, 3, 1'b1, 3);     // same vc keeps its depth
        drive(1'b1, 0, 1'b1, 3);     // different vcs
        drive(1'b1, 1, 1'b1, 0);
        drain_all();
        finish_test("write and read together", start);

        start = fail_count;
        drive(1'b1, 1, 1'b0, 0);
        drive(1'b0, 0, 1'b1, 1);
        idle_cycles(5);
        drive(1'b1, 0, 1'b0, 0);
        idle_cycles(3);
        drain_all();
        idle_cycles(4);
        finish_test("dout hold", start);

        $display("tests run %0d, tests failed %0d, reads checked %0d, check failures %0d",
                 tests_run, tests_failed, read_count, fail_count);
        if (fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== flit_buffer.f ====
design/flit_buffer_pkg.sv
design/vc_ram_if.sv
design/vc_ptr_ctrl.sv
design/flit_ram.sv
design/flit_buffer.sv
dv/flit_buffer_scoreboard.sv
dv/flit_buffer_tb.sv

// ==== Makefile ====
TOP = flit_buffer_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flit_buffer.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only --timing --assert -f flit_buffer.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
